// File: sim/mask_patterns.txt
# name mask_type direction pattern_w sensor_w pattern_hex frames first_row_hex (column 0 is the top bit)
# mask_type 0 repeat, 1 slide, 3 unnamed code run as repeat; direction 1 slides right
rep_a5 0 0 8 64 A5000000 6 A5A5A5A5A5A5A5A5
rep_w3 0 0 3 40 C0000000 5 DB6DB6DB6D000000
sl_l7 1 0 7 64 B2000000 20 B366CD9B366CD9B3
sl_r31 1 1 31 50 9E3779B9 40 9E3779B93C6EC000
sl_l3 1 0 3 17 40000000 15 4924800000000000
sl_r5 1 1 5 64 E8000000 12 EF7BDEF7BDEF7BDE
rep_t3 3 1 1 9 80000000 5 FF80000000000000
sl_r16 1 1 16 24 12340000 10 1234120000000000

// File: mask_gen_top.f
hw/mask_pkg.sv
hw/pattern_feeder.sv
hw/mask_row_reg.sv
hw/mask_publisher.sv
hw/mask_gen_top.sv
sim/mask_gen_checker.sv
sim/mask_gen_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the mask generator regression with Verilator and run it
# exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module mask_gen_tb -f mask_gen_top.f -Mdir obj_dir -o mask_gen_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/mask_gen_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

exit 0

// File: sim/mask_gen_tb.sv
// regression testbench for mask_gen_top, runs every test line of sim/mask_patterns.txt and checks each row
module mask_gen_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import mask_pkg::*;

	localparam int MAX_SENSOR_W = 64;

	logic                         clk = 1'b0;
	logic                         rst_n;
	logic                         clk_en;
	logic [SENSOR_W_BITS-1:0]     sensor_w;
	logic [PATTERN_IDX_BITS-1:0]  pattern_w;
	logic [0:PATTERN_BITS-1]      pattern;
	logic                         right_sliding;
	logic                         load_pattern;
	mask_type_e                   mask_type;
	logic [0:MAX_SENSOR_W-1]      mg_mask;
	logic                         rp_valid;

	// test table, one entry per data line
	string                    t_name[$];
	int                       t_type[$];
	int                       t_dir[$];
	int                       t_pw[$];
	int                       t_sw[$];
	logic [31:0]              t_pat[$];
	int                       t_frames[$];
	logic [0:MAX_SENSOR_W-1]  t_first[$];

	logic [31:0]  lcg_state = 32'hd8967b33;
	// clk_en as seen by the edge just sampled
	logic         edge_en;
	int           watchdog_ns = 0;

	mask_gen_top #(
		.MAX_SENSOR_W (MAX_SENSOR_W)
	) UUT (
		.clk           (clk),
		.rst_n         (rst_n),
		.clk_en        (clk_en),
		.sensor_w      (sensor_w),
		.pattern_w     (pattern_w),
		.pattern       (pattern),
		.right_sliding (right_sliding),
		.load_pattern  (load_pattern),
		.mask_type     (mask_type),
		.mg_mask       (mg_mask),
		.rp_valid      (rp_valid)
	);

	// 8 ns clock
	always #4 clk = ~clk;

	////////////////////
	// helpers
	////////////////////

	// clk_en low on roughly one cycle in four
	function automatic logic next_en();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return (lcg_state[31:30] != 2'b00);
	endfunction

	// column c carries pattern bit (c + k) mod pattern_w, zero from sensor_w on
	function automatic logic [0:MAX_SENSOR_W-1] expected_row(input logic [31:0] pat,
		input int pw, input int sw, input int k);
		logic [0:31]             bits;
		logic [0:MAX_SENSOR_W-1] r;
		int                      idx;
		bits = pat;
		r = '0;
		for (int c = 0; c < sw && c < MAX_SENSOR_W; c++)
		begin
			idx = ((c + k) % pw + pw) % pw;
			r[c] = bits[idx];
		end
		return r;
	endfunction

	task automatic check_mask(input string name, input logic [0:MAX_SENSOR_W-1] exp,
		input logic [0:MAX_SENSOR_W-1] act);
		if (act !== exp)
		begin
			$display("ERR %0s: mg_mask expected %h actual %h", name, exp, act);
			$display("Regression failed");
			$fatal(1, "mask row mismatch");
		end
	endtask

	task automatic check_valid(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("ERR %0s: rp_valid expected %b actual %b", name, exp, act);
			$display("Regression failed");
			$fatal(1, "valid flag mismatch");
		end
	endtask

	// one clock, new inputs go out at the rising edge, outputs are read at the falling edge
	task automatic apply_cycle(input logic en, input logic ld);
		@(posedge clk);
		edge_en = clk_en;
		clk_en       <= en;
		load_pattern <= ld;
		@(negedge clk);
	endtask

	task automatic read_patterns();
		int    fd;
		int    n;
		int    typ, dir, pw, sw, frames;
		string line;
		string nm;
		logic [31:0]             pat;
		logic [0:MAX_SENSOR_W-1] first;
		fd = $fopen("sim/mask_patterns.txt", "r");
		if (fd == 0)
		begin
			$display("could not open sim/mask_patterns.txt");
			$display("Regression failed");
			$fatal(1, "no stimulus file");
		end
		while (!$feof(fd))
		begin
			line = "";
			n = $fgets(line, fd);
			// skip comment and blank lines
			if (line.len() < 2 || line.getc(0) == 8'h23)
				continue;
			n = $sscanf(line, "%s %d %d %d %d %h %d %h", nm, typ, dir, pw, sw, pat, frames, first);
			if (n != 8)
			begin
				$display("malformed line in sim/mask_patterns.txt: %0s", line);
				$display("Regression failed");
				$fatal(1, "bad stimulus file");
			end
			t_name.push_back(nm);
			t_type.push_back(typ);
			t_dir.push_back(dir);
			t_pw.push_back(pw);
			t_sw.push_back(sw);
			t_pat.push_back(pat);
			t_frames.push_back(frames);
			t_first.push_back(first);
			// two wall cycles per needed enabled cycle covers the clk_en gaps
			watchdog_ns += (sw + frames + 4) * 2 * 8;
		end
		$fclose(fd);
		watchdog_ns += 2000;
	endtask

	////////////////////
	// test sequence
	////////////////////

	// config and load go out together, configuration then holds until the next load
	task automatic load_test(input int i);
		@(posedge clk);
		edge_en = clk_en;
		sensor_w      <= SENSOR_W_BITS'(t_sw[i]);
		pattern_w     <= PATTERN_IDX_BITS'(t_pw[i]);
		pattern       <= t_pat[i];
		right_sliding <= (t_dir[i] != 0);
		mask_type     <= mask_type_e'(2'(t_type[i]));
		clk_en        <= 1'b1;
		load_pattern  <= 1'b1;
		@(negedge clk);
	endtask

	task automatic run_test(input int i);
		logic [0:MAX_SENSOR_W-1] prev_mask;
		logic                    prev_valid;
		int                      frame;
		int                      en_edges;
		int                      k;
		frame = 0;
		en_edges = 0;
		// this sample is the load edge, valid drops even mid run
		apply_cycle(next_en(), 1'b0);
		check_valid(t_name[i], 1'b0, rp_valid);
		while (frame < t_frames[i])
		begin
			prev_mask  = mg_mask;
			prev_valid = rp_valid;
			apply_cycle(next_en(), 1'b0);
			if (!edge_en)
			begin
				// stalled edge, nothing may move
				check_mask(t_name[i], prev_mask, mg_mask);
				check_valid(t_name[i], prev_valid, rp_valid);
			end
			else if (frame > 0 || rp_valid)
			begin
				check_valid(t_name[i], 1'b1, rp_valid);
				if (frame == 0)
					check_mask(t_name[i], t_first[i], mg_mask);
				// repeat and unnamed codes hold offset 0, slide steps once per frame
				if (t_type[i] != 1)
					k = 0;
				else if (t_dir[i] != 0)
					k = -frame;
				else
					k = frame;
				check_mask(t_name[i], expected_row(t_pat[i], t_pw[i], t_sw[i], k), mg_mask);
				frame++;
			end
			else
			begin
				en_edges++;
				if (en_edges > t_sw[i] + 4)
				begin
					$display("rp_valid never rose after the fill in test %0s", t_name[i]);
					$display("Regression failed");
					$fatal(1, "no valid frame");
				end
			end
		end
	endtask

	initial
	begin
		wait (watchdog_ns > 0);
		#(watchdog_ns);
		$display("timeout, the tests did not finish within %0d ns", watchdog_ns);
		$display("Regression failed");
		$fatal(1, "watchdog expired");
	end

	initial
	begin
		rst_n         = 1'b0;
		clk_en        = 1'b0;
		load_pattern  = 1'b0;
		sensor_w      = '0;
		pattern_w     = '0;
		pattern       = '0;
		right_sliding = 1'b0;
		mask_type     = MASK_REPEAT;
		edge_en       = 1'b0;
		read_patterns();
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		// idle after reset, clock enabled and no load
		repeat (3) apply_cycle(1'b1, 1'b0);
		check_valid("reset", 1'b0, rp_valid);
		check_mask("reset", '0, mg_mask);
		// each new load lands while the previous test is still running
		for (int i = 0; i < t_name.size(); i++)
		begin
			load_test(i);
			run_test(i);
		end
		$display("Regression passed");
		$finish;
	end

endmodule

// File: sim/mask_gen_checker.sv
// protocol assertions for mask_gen_top, attached to every instance through the bind at the bottom
module mask_gen_checker #(
	parameter int MAX_SENSOR_W = 1920
) (
	input logic                                clk,
	input logic                                rst_n,
	input logic                                clk_en,
	input logic [mask_pkg::SENSOR_W_BITS-1:0]  sensor_w,
	input logic                                load_pattern,
	input logic [0:MAX_SENSOR_W-1]             mg_mask,
	input logic                                rp_valid
);
	timeunit 1ns;
	timeprecision 1ps;

	import mask_pkg::*;

	// ones on the active columns
	function automatic logic [0:MAX_SENSOR_W-1] active_cols(input logic [SENSOR_W_BITS-1:0] w);
		logic [0:MAX_SENSOR_W-1] keep;
		keep = '0;
		for (int c = 0; c < MAX_SENSOR_W; c++)
		begin
			if (c < w)
				keep[c] = 1'b1;
		end
		return keep;
	endfunction

	////////////////////
	// output rules
	////////////////////

	// reset holds the output idle
	assert property (@(posedge clk) !rst_n |-> (!rp_valid && mg_mask == '0))
		else $error("output not idle in reset");

	// an enabled load drops valid at once
	assert property (@(posedge clk) disable iff (!rst_n)
		(clk_en && load_pattern) |=> !rp_valid)
		else $error("rp_valid still high after a load");

	// sensor_w changes with the load, so the load cycle is left out
	assert property (@(posedge clk) disable iff (!rst_n)
		(rp_valid && !load_pattern) |-> ((mg_mask & ~active_cols(sensor_w)) == '0))
		else $error("mask column beyond sensor_w is set");

	// clk_en low freezes the outputs
	assert property (@(posedge clk) disable iff (!rst_n)
		!clk_en |=> ($stable(mg_mask) && $stable(rp_valid)))
		else $error("output moved on a stalled cycle");

endmodule

bind mask_gen_top mask_gen_checker #(
	.MAX_SENSOR_W (MAX_SENSOR_W)
) u_checker (
	.clk          (clk),
	.rst_n        (rst_n),
	.clk_en       (clk_en),
	.sensor_w     (sensor_w),
	.load_pattern (load_pattern),
	.mg_mask      (mg_mask),
	.rp_valid     (rp_valid)
);

// File: hw/mask_gen_top.sv
// mask generator top level, connects pattern feeder, row buffer and publisher for one sensor row
module mask_gen_top #(
	parameter int MAX_SENSOR_W = 1920
) (
	input  logic                                    clk,
	input  logic                                    rst_n,
	input  logic                                    clk_en,
	input  logic [mask_pkg::SENSOR_W_BITS-1:0]      sensor_w,
	input  logic [mask_pkg::PATTERN_IDX_BITS-1:0]   pattern_w,
	input  logic [0:mask_pkg::PATTERN_BITS-1]       pattern,
	input  logic                                    right_sliding,
	input  logic                                    load_pattern,
	input  mask_pkg::mask_type_e                    mask_type,
	output logic [0:MAX_SENSOR_W-1]                 mg_mask,
	output logic                                    rp_valid
);
	import mask_pkg::*;

	// feeder to buffer
	row_op_e                  row_op;
	logic                     in_bit;
	// feeder to publisher
	logic                     publish;
	logic                     invalidate;
	// buffer to publisher
	logic [0:MAX_SENSOR_W-1]  row;

	pattern_feeder u_feeder (
		.clk           (clk),
		.rst_n         (rst_n),
		.clk_en        (clk_en),
		.sensor_w      (sensor_w),
		.pattern_w     (pattern_w),
		.pattern       (pattern),
		.right_sliding (right_sliding),
		.load_pattern  (load_pattern),
		.mask_type     (mask_type),
		.row_op        (row_op),
		.in_bit        (in_bit),
		.publish       (publish),
		.invalidate    (invalidate)
	);

	mask_row_reg #(
		.MAX_SENSOR_W (MAX_SENSOR_W)
	) u_row (
		.clk      (clk),
		.rst_n    (rst_n),
		.clk_en   (clk_en),
		.sensor_w (sensor_w),
		.row_op   (row_op),
		.in_bit   (in_bit),
		.row      (row)
	);

	mask_publisher #(
		.MAX_SENSOR_W (MAX_SENSOR_W)
	) u_pub (
		.clk        (clk),
		.rst_n      (rst_n),
		.clk_en     (clk_en),
		.sensor_w   (sensor_w),
		.row        (row),
		.publish    (publish),
		.invalidate (invalidate),
		.mg_mask    (mg_mask),
		.rp_valid   (rp_valid)
	);

endmodule

// File: hw/mask_publisher.sv
// output stage that captures the mask row on publish, zeroes inactive columns and flags it valid
module mask_publisher #(
	parameter int MAX_SENSOR_W = 1920
) (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                clk_en,
	input  logic [mask_pkg::SENSOR_W_BITS-1:0]  sensor_w,
	input  logic [0:MAX_SENSOR_W-1]             row,
	input  logic                                publish,
	input  logic                                invalidate,
	output logic [0:MAX_SENSOR_W-1]             mg_mask,
	output logic                                rp_valid
);

	// ones on columns below sensor_w
	logic [0:MAX_SENSOR_W-1] col_keep;

	always_comb
	begin
		col_keep = '0;
		for (int c = 0; c < MAX_SENSOR_W; c++)
		begin
			if (c < sensor_w)
				col_keep[c] = 1'b1;
		end
	end

	////////////////////
	// published row
	////////////////////

	// mask is held between publishes, invalidate only drops the flag
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			mg_mask <= '0;
		else if (clk_en && publish && !invalidate)
			mg_mask <= row & col_keep;
	end

	////////////////////
	// valid flag
	////////////////////

	// invalidate wins, a load restarts the sequence
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			rp_valid <= 1'b0;
		else if (clk_en)
		begin
			if (invalidate)
				rp_valid <= 1'b0;
			else if (publish)
				rp_valid <= 1'b1;
		end
	end

endmodule

// File: hw/mask_row_reg.sv
// mask row buffer, cleared and shifted one column per enabled cycle under feeder control
module mask_row_reg #(
	parameter int MAX_SENSOR_W = 1920
) (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                clk_en,
	input  logic [mask_pkg::SENSOR_W_BITS-1:0]  sensor_w,
	input  mask_pkg::row_op_e                   row_op,
	input  logic                                in_bit,
	output logic [0:MAX_SENSOR_W-1]             row
);
	import mask_pkg::*;

	// column 0 is index 0, as on the sensor
	logic [0:MAX_SENSOR_W-1]   row_next;
	logic [0:MAX_SENSOR_W-1]   left_ins;
	logic [SENSOR_W_BITS-1:0]  last_col;
	logic                      last_in_range;

	// entry column for left shifts
	// sensor_w of zero wraps to 2047 and never matches a column
	assign last_col      = sensor_w - 1'b1;
	assign last_in_range = (sensor_w != '0) && (sensor_w <= MAX_SENSOR_W);

	////////////////////
	// insert position
	////////////////////

	// one-hot select of column sensor_w-1
	always_comb
	begin
		left_ins = '0;
		for (int c = 0; c < MAX_SENSOR_W; c++)
		begin
			if (last_in_range && (c == last_col))
				left_ins[c] = 1'b1;
		end
	end

	////////////////////
	// next row
	////////////////////

	always_comb
	begin
		row_next = row;
		case (row_op)
			ROW_CLEAR:
			begin
				row_next = '0;
			end
			ROW_SHIFT_LEFT:
			begin
				// every column moves down by one
				row_next = {row[1:MAX_SENSOR_W-1], 1'b0};
				// entering bit lands at the last active column
				for (int c = 0; c < MAX_SENSOR_W; c++)
				begin
					if (left_ins[c])
						row_next[c] = in_bit;
				end
			end
			ROW_SHIFT_RIGHT:
			begin
				// every column moves up by one, entering bit at column 0
				// column sensor_w picks up a stale bit here, the publisher masks it
				row_next = {in_bit, row[0:MAX_SENSOR_W-2]};
			end
			default:
			begin
				row_next = row;
			end
		endcase
	end

	////////////////////
	// row register
	////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			row <= '0;
		else if (clk_en)
			row <= row_next;
	end

endmodule

// File: hw/pattern_feeder.sv
// stores the loaded pattern and sequences load, fill and run, driving the row buffer bit by bit
module pattern_feeder (
	input  logic                                    clk,
	input  logic                                    rst_n,
	input  logic                                    clk_en,
	input  logic [mask_pkg::SENSOR_W_BITS-1:0]      sensor_w,
	input  logic [mask_pkg::PATTERN_IDX_BITS-1:0]   pattern_w,
	input  logic [0:mask_pkg::PATTERN_BITS-1]       pattern,
	input  logic                                    right_sliding,
	input  logic                                    load_pattern,
	input  mask_pkg::mask_type_e                    mask_type,
	output mask_pkg::row_op_e                       row_op,
	output logic                                    in_bit,
	output logic                                    publish,
	output logic                                    invalidate
);
	import mask_pkg::*;

	typedef enum logic [1:0] {
		PH_IDLE,
		PH_FILL,
		PH_RUN
	} phase_e;

	// pattern bit 0 sits at index 0, the first bit of the word
	logic [0:PATTERN_BITS-1]      stored_pattern;
	logic [PATTERN_IDX_BITS-1:0]  fwd_ptr;
	logic [PATTERN_IDX_BITS-1:0]  back_ptr;
	logic [SENSOR_W_BITS-1:0]     fill_cnt;
	logic                         first_run;
	logic                         fill_done;
	logic                         slide_mode;
	phase_e                       phase;

	// pointer steps, modulo pattern_w
	function automatic logic [PATTERN_IDX_BITS-1:0] ptr_up(
		input logic [PATTERN_IDX_BITS-1:0] p,
		input logic [PATTERN_IDX_BITS-1:0] w
	);
		ptr_up = (p == w - 1'b1) ? '0 : p + 1'b1;
	endfunction

	function automatic logic [PATTERN_IDX_BITS-1:0] ptr_down(
		input logic [PATTERN_IDX_BITS-1:0] p,
		input logic [PATTERN_IDX_BITS-1:0] w
	);
		ptr_down = (p == '0) ? w - 1'b1 : p - 1'b1;
	endfunction

	// unknown mask codes run as repeat
	assign slide_mode = (mask_type == MASK_SLIDE);
	// last fill shift is the one that brings the count up to sensor_w
	assign fill_done  = (fill_cnt + SENSOR_W_BITS'(1) >= sensor_w);
	// a load always drops the published row
	assign invalidate = load_pattern;

	////////////////////
	// pattern store
	////////////////////

	always_ff @(posedge clk)
	begin
		if (clk_en && load_pattern)
			stored_pattern <= pattern;
	end

	////////////////////
	// phase control
	////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			phase     <= PH_IDLE;
			fwd_ptr   <= '0;
			back_ptr  <= '0;
			fill_cnt  <= '0;
			first_run <= 1'b0;
		end
		else if (clk_en)
		begin
			if (load_pattern)
			begin
				// restart from any phase, back pointer sits one step behind bit 0
				phase     <= PH_FILL;
				fwd_ptr   <= '0;
				back_ptr  <= pattern_w - 1'b1;
				fill_cnt  <= '0;
				first_run <= 1'b0;
			end
			else
			begin
				case (phase)
					PH_FILL:
					begin
						fwd_ptr  <= ptr_up(fwd_ptr, pattern_w);
						fill_cnt <= fill_cnt + 1'b1;
						if (fill_done)
						begin
							phase     <= PH_RUN;
							first_run <= 1'b1;
						end
					end
					PH_RUN:
					begin
						first_run <= 1'b0;
						// both pointers move together so either direction stays aligned
						if (slide_mode && right_sliding)
						begin
							fwd_ptr  <= ptr_down(fwd_ptr, pattern_w);
							back_ptr <= ptr_down(back_ptr, pattern_w);
						end
						else if (slide_mode)
						begin
							fwd_ptr  <= ptr_up(fwd_ptr, pattern_w);
							back_ptr <= ptr_up(back_ptr, pattern_w);
						end
					end
					default:
					begin
						phase <= PH_IDLE;
					end
				endcase
			end
		end
	end

	////////////////////
	// row commands
	////////////////////

	always_comb
	begin
		row_op  = ROW_HOLD;
		in_bit  = 1'b0;
		publish = 1'b0;
		if (load_pattern)
			row_op = ROW_CLEAR;
		else if (phase == PH_FILL)
		begin
			row_op = ROW_SHIFT_LEFT;
			in_bit = stored_pattern[fwd_ptr];
		end
		else if (phase == PH_RUN)
		begin
			if (slide_mode)
			begin
				// publish the current offset, the shift lands after it
				publish = 1'b1;
				row_op  = right_sliding ? ROW_SHIFT_RIGHT : ROW_SHIFT_LEFT;
				in_bit  = right_sliding ? stored_pattern[back_ptr] : stored_pattern[fwd_ptr];
			end
			else
				publish = first_run;
		end
	end

endmodule

// File: hw/mask_pkg.sv
// shared widths and enum types for the coded-exposure mask generator, compile before the RTL
package mask_pkg;

	////////////////////
	// widths
	////////////////////

	// bits in the loaded pattern word
	localparam int PATTERN_BITS = 32;

	// pattern_w and the fwd/back pattern pointers
	localparam int PATTERN_IDX_BITS = 5;

	// sensor_w and the fill counter, enough for a 1920 column sensor
	localparam int SENSOR_W_BITS = 11;

	////////////////////
	// opcodes
	////////////////////

	// mask type selected by the host
	// codes 10 and 11 are not named and fall back to repeat
	typedef enum logic [1:0] {
		MASK_REPEAT = 2'b00,
		MASK_SLIDE  = 2'b01
	} mask_type_e;

	// command from the pattern feeder to the row buffer
	// left shift enters at column sensor_w-1, right shift enters at column 0
	typedef enum logic [1:0] {
		ROW_HOLD        = 2'b00,
		ROW_CLEAR       = 2'b01,
		ROW_SHIFT_LEFT  = 2'b10,
		ROW_SHIFT_RIGHT = 2'b11
	} row_op_e;

endpackage
